/* icache_params.svh */
// Geometry of the L1 instruction cache
// Two ways of 16 sets, one 64-bit block per line

`ifndef ICACHE_PARAMS_SVH
`define ICACHE_PARAMS_SVH

// Physical address split as tag | index | byte offset
`define ICACHE_ADDR_W    16
`define ICACHE_SETS      16
`define ICACHE_INDEX_W   4
`define ICACHE_OFFSET_W  3
`define ICACHE_TAG_W     9

// A block holds two instructions
`define ICACHE_INSTR_W   32
`define ICACHE_BLOCK_W   64

// Fixed at two, since each set keeps a single LRU bit
`define ICACHE_WAYS      2

`endif

/* icache_pkg.sv */
// Shared types of the instruction cache
// Address fields, data words and the miss engine message type

`default_nettype none

package icache_pkg;

  `include "icache_params.svh"

  // Fetch pipeline state
  typedef enum logic [1:0] {
    e_ready,
    e_miss,
    e_recover
  } state_e;

  // Only block loads are sent to the engine
  typedef enum logic {
    e_miss_load = 1'b0
  } req_msg_e;

  typedef logic [`ICACHE_ADDR_W-1:0]  addr_t;
  typedef logic [`ICACHE_TAG_W-1:0]   tag_t;
  typedef logic [`ICACHE_INDEX_W-1:0] index_t;
  typedef logic [`ICACHE_BLOCK_W-1:0] block_t;
  typedef logic [`ICACHE_INSTR_W-1:0] instr_t;

endpackage

`default_nettype wire

/* icache_decode.sv */
// Decode stage of the instruction cache
// Accepts fetch requests and drives the synchronous array read

`timescale 1ns/1ps
`default_nettype none

`include "icache_params.svh"

module icache_decode (
  input  wire logic                clk_i,
  input  wire logic                reset_i,
  input  wire icache_pkg::addr_t   addr_i,
  input  wire logic                v_i,
  output logic                     yumi_o,
  input  wire icache_pkg::state_e  state_i,
  input  wire logic                tl_full_i,
  input  wire logic                tv_we_i,
  output logic                     rd_v_o,
  output icache_pkg::index_t       rd_index_o,
  output logic                     tl_we_o,
  output icache_pkg::addr_t        tl_addr_o
);

  icache_pkg::addr_t tl_addr_q;
  logic              is_ready;
  logic              is_recover;

  assign is_ready   = (state_i == icache_pkg::e_ready);
  assign is_recover = (state_i == icache_pkg::e_recover);

  // Accept when the lookup slot is free or drains into verify this cycle
  assign yumi_o = v_i && is_ready && (!tl_full_i || tv_we_i);

  // The lookup slot changes on a new request or when its entry moves on
  assign tl_we_o = yumi_o || tv_we_i;

  // Recover re-reads the arrays for the request still held in lookup
  assign rd_v_o     = yumi_o || (is_recover && tl_full_i);
  assign rd_index_o = is_recover
                    ? tl_addr_q[`ICACHE_OFFSET_W +: `ICACHE_INDEX_W]
                    : addr_i[`ICACHE_OFFSET_W +: `ICACHE_INDEX_W];

  // Lookup stage address
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      tl_addr_q <= '0;
    else if (yumi_o)
      tl_addr_q <= addr_i;
  end

  assign tl_addr_o = tl_addr_q;

endmodule

`default_nettype wire

/* icache_lookup.sv */
// Lookup stage of the instruction cache
// Valid, tag, data and LRU arrays with tag compare and replacement choice

`timescale 1ns/1ps
`default_nettype none

`include "icache_params.svh"

module icache_lookup (
  input  wire logic                clk_i,
  input  wire logic                reset_i,
  input  wire logic                rd_v_i,
  input  wire icache_pkg::index_t  rd_index_i,
  input  wire logic                tl_we_i,
  input  wire icache_pkg::addr_t   tl_addr_i,
  input  wire logic                fill_we_i,
  input  wire logic                fill_way_i,
  input  wire icache_pkg::block_t  fill_data_i,
  input  wire logic                lru_we_i,
  input  wire logic                lru_way_i,
  output logic                     tl_full_o,
  output icache_pkg::addr_t        tl_addr_o,
  output logic                     hit_o,
  output logic                     hit_way_o,
  output icache_pkg::instr_t       instr_o,
  output logic                     repl_way_o
);

  logic [`ICACHE_WAYS-1:0][`ICACHE_SETS-1:0] valid_mem;
  icache_pkg::tag_t                          tag_mem  [`ICACHE_WAYS][`ICACHE_SETS];
  icache_pkg::block_t                        data_mem [`ICACHE_WAYS][`ICACHE_SETS];
  logic [`ICACHE_SETS-1:0]                   lru_mem;

  logic [`ICACHE_WAYS-1:0] valid_rd_q;
  icache_pkg::tag_t        tag_rd_q  [`ICACHE_WAYS];
  icache_pkg::block_t      data_rd_q [`ICACHE_WAYS];
  logic                    lru_rd_q;
  logic                    lru_rd_n;
  logic                    lru_eff;

  logic                    tl_full_q;
  icache_pkg::addr_t       tv_addr_q;
  icache_pkg::index_t      tl_index;
  icache_pkg::index_t      tv_index;
  icache_pkg::tag_t        tl_tag;
  icache_pkg::tag_t        tv_tag;
  logic [`ICACHE_WAYS-1:0] way_hit;
  icache_pkg::block_t      hit_block;

  assign tl_index = tl_addr_i[`ICACHE_OFFSET_W +: `ICACHE_INDEX_W];
  assign tl_tag   = tl_addr_i[`ICACHE_ADDR_W-1 -: `ICACHE_TAG_W];
  assign tv_index = tv_addr_q[`ICACHE_OFFSET_W +: `ICACHE_INDEX_W];
  assign tv_tag   = tv_addr_q[`ICACHE_ADDR_W-1 -: `ICACHE_TAG_W];

  // Slot is rewritten only when empty or when its entry enters verify,
  // so a write over a full slot hands that address to verify
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      tl_full_q <= 1'b0;
    else if (tl_we_i)
      tl_full_q <= rd_v_i;
  end

  always_ff @(posedge clk_i)
  begin
    if (tl_we_i && tl_full_q)
      tv_addr_q <= tl_addr_i;
  end

  //////////////////////////////////////////////////////////////////////
  // Arrays, written by fills and hits at the verify address
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      valid_mem <= '0;
      lru_mem   <= '0;
    end
    else
    begin
      if (fill_we_i)
        valid_mem[fill_way_i][tv_index] <= 1'b1;
      if (lru_we_i)
        lru_mem[tv_index] <= lru_way_i;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (fill_we_i)
    begin
      tag_mem[fill_way_i][tv_index]  <= tv_tag;
      data_mem[fill_way_i][tv_index] <= fill_data_i;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (rd_v_i)
    begin
      for (int w = 0; w < `ICACHE_WAYS; w++)
      begin
        tag_rd_q[w]  <= tag_mem[w][rd_index_i];
        data_rd_q[w] <= data_mem[w][rd_index_i];
      end
    end
  end

  // LRU write of a delivered hit is forwarded into the held read value
  assign lru_eff  = (lru_we_i && (tv_index == tl_index)) ? lru_way_i : lru_rd_q;
  assign lru_rd_n = !rd_v_i ? lru_eff
                  : (lru_we_i && (tv_index == rd_index_i)) ? lru_way_i
                  : lru_mem[rd_index_i];

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      valid_rd_q <= '0;
      lru_rd_q   <= 1'b0;
    end
    else
    begin
      if (rd_v_i)
      begin
        for (int w = 0; w < `ICACHE_WAYS; w++)
          valid_rd_q[w] <= valid_mem[w][rd_index_i];
      end
      lru_rd_q <= lru_rd_n;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Tag compare and selection
  //////////////////////////////////////////////////////////////////////
  always_comb
  begin
    for (int w = 0; w < `ICACHE_WAYS; w++)
      way_hit[w] = valid_rd_q[w] && (tag_rd_q[w] == tl_tag);
  end

  assign hit_o     = tl_full_q && (|way_hit);
  assign hit_way_o = way_hit[1];
  assign hit_block = data_rd_q[hit_way_o];

  // A fill presents the verify word straight from the incoming block
  always_comb
  begin
    if (fill_we_i)
      instr_o = tv_addr_q[`ICACHE_OFFSET_W-1]
              ? fill_data_i[`ICACHE_INSTR_W +: `ICACHE_INSTR_W]
              : fill_data_i[0 +: `ICACHE_INSTR_W];
    else
      instr_o = tl_addr_i[`ICACHE_OFFSET_W-1]
              ? hit_block[`ICACHE_INSTR_W +: `ICACHE_INSTR_W]
              : hit_block[0 +: `ICACHE_INSTR_W];
  end

  // Invalid way first, else the way not used last
  always_comb
  begin
    if (!valid_rd_q[0])
      repl_way_o = 1'b0;
    else if (!valid_rd_q[1])
      repl_way_o = 1'b1;
    else
      repl_way_o = ~lru_eff;
  end

  assign tl_full_o = tl_full_q;
  assign tl_addr_o = tl_addr_i;

endmodule

`default_nettype wire

/* icache_miss_ctrl.sv */
// Verify stage and miss control of the instruction cache
// Delivers hits, requests missing blocks and sequences fill and recovery

`timescale 1ns/1ps
`default_nettype none

`include "icache_params.svh"

module icache_miss_ctrl (
  input  wire logic                clk_i,
  input  wire logic                reset_i,
  input  wire logic                tl_full_i,
  input  wire icache_pkg::addr_t   tl_addr_i,
  input  wire logic                hit_i,
  input  wire logic                hit_way_i,
  input  wire icache_pkg::instr_t  instr_i,
  input  wire logic                repl_way_i,
  input  wire logic                yumi_i,
  input  wire logic                fill_v_i,
  output icache_pkg::instr_t       data_o,
  output logic                     data_v_o,
  output icache_pkg::addr_t        req_addr_o,
  output icache_pkg::req_msg_e     req_type_o,
  output logic                     req_v_o,
  input  wire logic                req_yumi_i,
  output logic                     tv_we_o,
  output icache_pkg::state_e       state_o,
  output logic                     fill_we_o,
  output logic                     fill_way_o,
  output logic                     lru_we_o,
  output logic                     lru_way_o
);

  icache_pkg::state_e state_q;
  icache_pkg::state_e state_n;
  logic               tv_v_q;
  logic               tv_hit_q;
  logic               tv_way_q;
  icache_pkg::addr_t  tv_addr_q;
  icache_pkg::instr_t tv_instr_q;
  logic               is_ready;
  logic               deliver;
  logic               tv_we;
  logic               fill_we;

  assign is_ready = (state_q == icache_pkg::e_ready);
  assign data_v_o = is_ready && tv_v_q && tv_hit_q;
  assign deliver  = data_v_o && yumi_i;
  assign req_v_o  = is_ready && tv_v_q && !tv_hit_q;
  assign fill_we  = (state_q == icache_pkg::e_miss) && fill_v_i;

  // Verify loads only when empty or when its result leaves this cycle
  assign tv_we = is_ready && tl_full_i && (!tv_v_q || deliver);

  //////////////////////////////////////////////////////////////////////
  // Ready / miss / recover
  //////////////////////////////////////////////////////////////////////
  always_comb
  begin
    state_n = state_q;
    case (state_q)
      icache_pkg::e_ready:
      begin
        if (req_v_o && req_yumi_i)
          state_n = icache_pkg::e_miss;
      end
      icache_pkg::e_miss:
      begin
        if (fill_v_i)
          state_n = icache_pkg::e_recover;
      end
      default:
        state_n = icache_pkg::e_ready;
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      state_q <= icache_pkg::e_ready;
      tv_v_q  <= 1'b0;
    end
    else
    begin
      state_q <= state_n;
      if (tv_we)
        tv_v_q <= 1'b1;
      else if (deliver)
        tv_v_q <= 1'b0;
    end
  end

  // tv_way holds the hit way, or the way a miss will be filled into
  always_ff @(posedge clk_i)
  begin
    if (tv_we)
    begin
      tv_addr_q  <= tl_addr_i;
      tv_hit_q   <= hit_i;
      tv_way_q   <= hit_i ? hit_way_i : repl_way_i;
      tv_instr_q <= instr_i;
    end
    else if (fill_we)
    begin
      tv_hit_q   <= 1'b1;
      tv_instr_q <= instr_i;
    end
  end

  assign data_o     = tv_instr_q;
  assign req_addr_o = {tv_addr_q[`ICACHE_ADDR_W-1:`ICACHE_OFFSET_W], {`ICACHE_OFFSET_W{1'b0}}};
  assign req_type_o = icache_pkg::e_miss_load;

  assign tv_we_o    = tv_we;
  assign state_o    = state_q;
  assign fill_we_o  = fill_we;
  assign fill_way_o = tv_way_q;

  // Every delivered instruction marks its way as most recent
  assign lru_we_o  = deliver;
  assign lru_way_o = tv_way_q;

endmodule

`default_nettype wire

/* icache_top.sv */
// Two-way L1 instruction cache
// Decode, lookup and verify stages with a miss request and fill port

`timescale 1ns/1ps
`default_nettype none

module icache_top (
  input  wire logic                clk_i,
  input  wire logic                reset_i,
  input  wire icache_pkg::addr_t   addr_i,
  input  wire logic                v_i,
  output logic                     yumi_o,
  output icache_pkg::instr_t       data_o,
  output logic                     data_v_o,
  input  wire logic                yumi_i,
  output icache_pkg::addr_t        req_addr_o,
  output icache_pkg::req_msg_e     req_type_o,
  output logic                     req_v_o,
  input  wire logic                req_yumi_i,
  input  wire logic                fill_v_i,
  input  wire icache_pkg::block_t  fill_data_i
);

  logic               rd_v;
  icache_pkg::index_t rd_index;
  logic               tl_we;
  icache_pkg::addr_t  tl_addr_dec;
  logic               tl_full;
  icache_pkg::addr_t  tl_addr_lk;
  logic               hit;
  logic               hit_way;
  icache_pkg::instr_t instr;
  logic               repl_way;
  logic               tv_we;
  icache_pkg::state_e state;
  logic               fill_we;
  logic               fill_way;
  logic               lru_we;
  logic               lru_way;

  icache_decode u_decode (
    .clk_i(clk_i), .reset_i(reset_i),
    .addr_i(addr_i), .v_i(v_i), .yumi_o(yumi_o),
    .state_i(state), .tl_full_i(tl_full), .tv_we_i(tv_we),
    .rd_v_o(rd_v), .rd_index_o(rd_index),
    .tl_we_o(tl_we), .tl_addr_o(tl_addr_dec)
  );

  icache_lookup u_lookup (
    .clk_i(clk_i), .reset_i(reset_i),
    .rd_v_i(rd_v), .rd_index_i(rd_index),
    .tl_we_i(tl_we), .tl_addr_i(tl_addr_dec),
    .fill_we_i(fill_we), .fill_way_i(fill_way), .fill_data_i(fill_data_i),
    .lru_we_i(lru_we), .lru_way_i(lru_way),
    .tl_full_o(tl_full), .tl_addr_o(tl_addr_lk),
    .hit_o(hit), .hit_way_o(hit_way), .instr_o(instr), .repl_way_o(repl_way)
  );

  icache_miss_ctrl u_miss_ctrl (
    .clk_i(clk_i), .reset_i(reset_i),
    .tl_full_i(tl_full), .tl_addr_i(tl_addr_lk),
    .hit_i(hit), .hit_way_i(hit_way), .instr_i(instr), .repl_way_i(repl_way),
    .yumi_i(yumi_i), .fill_v_i(fill_v_i),
    .data_o(data_o), .data_v_o(data_v_o),
    .req_addr_o(req_addr_o), .req_type_o(req_type_o),
    .req_v_o(req_v_o), .req_yumi_i(req_yumi_i),
    .tv_we_o(tv_we), .state_o(state),
    .fill_we_o(fill_we), .fill_way_o(fill_way),
    .lru_we_o(lru_we), .lru_way_o(lru_way)
  );

endmodule

`default_nettype wire

/* icache_assert.sv */
// Handshake checks for the instruction cache
// Bound into the top level next to the DUT

`timescale 1ns/1ps
`default_nettype none

module icache_assert (
  input wire logic                clk_i,
  input wire logic                reset_i,
  input wire logic                fetch_yumi_i,
  input wire logic                data_v_i,
  input wire icache_pkg::instr_t  data_i,
  input wire logic                yumi_i,
  input wire logic                req_v_i,
  input wire icache_pkg::addr_t   req_addr_i,
  input wire logic                req_yumi_i,
  input wire logic                fill_v_i,
  input wire icache_pkg::state_e  state_i
);

  int   fail_cnt;
  logic miss_open_q;

  initial
    fail_cnt = 0;

  // Engine owns the block from the request handshake until the fill strobe
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      miss_open_q <= 1'b0;
    else if (req_v_i && req_yumi_i)
      miss_open_q <= 1'b1;
    else if (fill_v_i)
      miss_open_q <= 1'b0;
  end

  // Miss request waits for the engine
  req_stable_a: assert property (@(posedge clk_i) disable iff (reset_i)
    req_v_i && !req_yumi_i |=> req_v_i && $stable(req_addr_i))
  else
  begin
    fail_cnt++;
    $error("miss request changed before the engine took it");
  end

  // Result waits for the consumer
  data_stable_a: assert property (@(posedge clk_i) disable iff (reset_i)
    data_v_i && !yumi_i |=> data_v_i && $stable(data_i))
  else
  begin
    fail_cnt++;
    $error("result changed before it was taken");
  end

  no_accept_in_miss_a: assert property (@(posedge clk_i) disable iff (reset_i)
    miss_open_q |-> !fetch_yumi_i)
  else
  begin
    fail_cnt++;
    $error("fetch accepted while a miss is outstanding");
  end

  // The miss state is entered only through a request handshake
  fill_after_req_a: assert property (@(posedge clk_i) disable iff (reset_i)
    fill_v_i |-> state_i == icache_pkg::e_miss)
  else
  begin
    fail_cnt++;
    $error("fill strobe without an accepted miss request");
  end

endmodule

bind icache_top icache_assert u_assert (
  .clk_i(clk_i), .reset_i(reset_i),
  .fetch_yumi_i(yumi_o), .data_v_i(data_v_o), .data_i(data_o), .yumi_i(yumi_i),
  .req_v_i(req_v_o), .req_addr_i(req_addr_o), .req_yumi_i(req_yumi_i),
  .fill_v_i(fill_v_i), .state_i(state)
);

`default_nettype wire

/* icache_tb.sv */
// Testbench for the two-way instruction cache
// Fill engine model, reference tags and LRU, six directed tests

`timescale 1ns/1ps
`default_nettype none

`include "icache_params.svh"

module icache_tb;

  localparam int CLK_PERIOD      = 20;
  localparam int TEST_COUNT      = 6;
  localparam int CYCLES_PER_TEST = 400;
  localparam int WAIT_LIMIT      = 100;
  localparam int STREAM_LEN      = 24;

  localparam icache_pkg::index_t SET_IDX    = 4'd6;
  localparam icache_pkg::tag_t   TAG_A      = 9'h024;
  localparam icache_pkg::tag_t   TAG_B      = 9'h02C;
  localparam icache_pkg::tag_t   TAG_C      = 9'h034;
  localparam icache_pkg::tag_t   STREAM_TAG = 9'h0A5;

  logic                 clk_i;
  logic                 reset_i;
  icache_pkg::addr_t    addr_i;
  logic                 v_i;
  logic                 yumi_o;
  icache_pkg::instr_t   data_o;
  logic                 data_v_o;
  logic                 yumi_i;
  icache_pkg::addr_t    req_addr_o;
  icache_pkg::req_msg_e req_type_o;
  logic                 req_v_o;
  logic                 req_yumi_i;
  logic                 fill_v_i;
  icache_pkg::block_t   fill_data_i;

  int                   cycle;
  int                   errors;
  int                   checks;
  int                   tests_done;
  int                   test_err_start;
  int                   req_count;
  int                   fill_delay;
  icache_pkg::addr_t    last_req_addr;
  string                cur_test;
  logic                 gap_mode;
  logic [31:0]          rng_state;
  logic                 held_v;
  icache_pkg::instr_t   held_data;
  icache_pkg::instr_t   res_data [$];
  int                   res_cycle [$];

  // Reference copy of the tags, valid bits and LRU
  icache_pkg::tag_t     mdl_tag   [`ICACHE_WAYS][`ICACHE_SETS];
  logic                 mdl_valid [`ICACHE_WAYS][`ICACHE_SETS];
  logic                 mdl_lru   [`ICACHE_SETS];

  icache_top dut (
    .clk_i(clk_i), .reset_i(reset_i),
    .addr_i(addr_i), .v_i(v_i), .yumi_o(yumi_o),
    .data_o(data_o), .data_v_o(data_v_o), .yumi_i(yumi_i),
    .req_addr_o(req_addr_o), .req_type_o(req_type_o),
    .req_v_o(req_v_o), .req_yumi_i(req_yumi_i),
    .fill_v_i(fill_v_i), .fill_data_i(fill_data_i)
  );

  initial
  begin
    clk_i = 1'b0;
    forever
      #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  always @(posedge clk_i)
    cycle <= cycle + 1;

  initial
  begin : watchdog
    #(TEST_COUNT * CYCLES_PER_TEST * CLK_PERIOD);
    $display("Run exceeded its time limit and was stopped");
    $display("TB FAILED");
    $finish;
  end

  //////////////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////////////
  function automatic logic [31:0] next_random();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  // Each word of memory holds its own address
  function automatic icache_pkg::instr_t expected_instr(input icache_pkg::addr_t addr);
    return 32'({addr[`ICACHE_ADDR_W-1:2], 2'b00});
  endfunction

  // Start of the 8-byte block that holds the address
  function automatic icache_pkg::addr_t block_addr(input icache_pkg::addr_t addr);
    return icache_pkg::addr_t'(addr - addr % (`ICACHE_BLOCK_W / 8));
  endfunction

  function automatic icache_pkg::addr_t make_addr(input icache_pkg::tag_t tag,
                                                  input icache_pkg::index_t index,
                                                  input logic word);
    return {tag, index, word, 2'b00};
  endfunction

  // Hit in either way, else fill an invalid way or the one not used last
  function automatic logic model_access(input icache_pkg::addr_t addr);
    icache_pkg::index_t idx;
    icache_pkg::tag_t   tag;
    logic               way;
    logic               hit;
    idx = addr[`ICACHE_OFFSET_W +: `ICACHE_INDEX_W];
    tag = addr[`ICACHE_ADDR_W-1 -: `ICACHE_TAG_W];
    hit = 1'b0;
    way = 1'b0;
    for (int w = 0; w < `ICACHE_WAYS; w++)
    begin
      if (mdl_valid[w][idx] && mdl_tag[w][idx] == tag)
      begin
        hit = 1'b1;
        way = 1'(w);
      end
    end
    if (!hit)
    begin
      if (!mdl_valid[0][idx])
        way = 1'b0;
      else if (!mdl_valid[1][idx])
        way = 1'b1;
      else
        way = ~mdl_lru[idx];
      mdl_valid[way][idx] = 1'b1;
      mdl_tag[way][idx]   = tag;
    end
    mdl_lru[idx] = way;
    return hit;
  endfunction

  task automatic compare_value(input string what, input logic [31:0] exp,
                               input logic [31:0] act);
    checks++;
    assert (act === exp)
    else
    begin
      errors++;
      $display("FAILED %s: %s expected %h actual %h", cur_test, what, exp, act);
    end
  endtask

  task automatic require(input logic cond, input string msg);
    checks++;
    assert (cond)
    else
    begin
      errors++;
      $display("ERROR %s: %s", cur_test, msg);
    end
  endtask

  task automatic start_test(input string name);
    cur_test       = name;
    test_err_start = errors;
  endtask

  task automatic report_test(input int num);
    $display("test %0d %s: %0d errors", num, cur_test, errors - test_err_start);
    tests_done++;
  endtask

  // Offers one address and returns once it was taken, still at +2 ns
  task automatic issue_fetch(input icache_pkg::addr_t addr, output int acc_cycle);
    logic accepted;
    int   waited;
    accepted  = 1'b0;
    waited    = 0;
    acc_cycle = 0;
    v_i       = 1'b1;
    addr_i    = addr;
    while (!accepted && waited < WAIT_LIMIT)
    begin
      @(negedge clk_i);
      accepted  = yumi_o;
      acc_cycle = cycle;
      @(posedge clk_i);
      #2;
      waited++;
    end
    require(accepted, "fetch request was never accepted");
  endtask

  task automatic wait_results(input int n);
    int waited;
    waited = 0;
    while (res_data.size() < n && waited < WAIT_LIMIT)
    begin
      @(posedge clk_i);
      #2;
      waited++;
    end
    require(res_data.size() >= n, "result did not arrive in time");
  endtask

  // Single fetch with hit or miss predicted by the reference model
  task automatic fetch_one(input icache_pkg::addr_t addr, output logic missed,
                           output int latency);
    logic exp_hit;
    int   reqs_before;
    int   acc_cycle;
    exp_hit     = model_access(addr);
    reqs_before = req_count;
    latency     = -1;
    res_data.delete();
    res_cycle.delete();
    issue_fetch(addr, acc_cycle);
    v_i = 1'b0;
    wait_results(1);
    missed = (req_count != reqs_before);
    compare_value("miss requests", !exp_hit, req_count - reqs_before);
    if (res_data.size() > 0)
    begin
      compare_value("instruction", expected_instr(addr), res_data[0]);
      latency = res_cycle[0] - acc_cycle;
    end
    if (missed)
      compare_value("miss address", block_addr(addr), last_req_addr);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Fill engine and result consumer
  //////////////////////////////////////////////////////////////////////
  initial
  begin : fill_engine
    forever
    begin
      @(posedge clk_i);
      #2;
      if (req_v_o)
      begin
        compare_value("request type", icache_pkg::e_miss_load, req_type_o);
        last_req_addr = req_addr_o;
        req_yumi_i    = 1'b1;
        @(posedge clk_i);
        #2;
        req_yumi_i = 1'b0;
        req_count++;
        fill_delay = next_random() % 6;
        repeat (fill_delay)
        begin
          @(posedge clk_i);
          #2;
        end
        fill_data_i = {32'(last_req_addr + 16'd4), 32'(last_req_addr)};
        fill_v_i    = 1'b1;
        @(posedge clk_i);
        #2;
        fill_v_i = 1'b0;
      end
    end
  end

  initial
  begin : result_sink
    held_v    = 1'b0;
    held_data = '0;
    forever
    begin
      @(posedge clk_i);
      #2;
      if (gap_mode)
        yumi_i = (next_random() % 3) != 0;
      else
        yumi_i = 1'b1;
      @(negedge clk_i);
      if (held_v)
      begin
        require(data_v_o, "result withdrawn while stalled");
        compare_value("held instruction", held_data, data_o);
      end
      if (data_v_o && yumi_i)
      begin
        res_data.push_back(data_o);
        res_cycle.push_back(cycle);
      end
      held_v    = data_v_o && !yumi_i;
      held_data = data_o;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////////////////////////
  task automatic reset_idle();
    start_test("reset_idle");
    repeat (5)
    begin
      @(negedge clk_i);
      compare_value("yumi_o", 0, yumi_o);
      compare_value("data_v_o", 0, data_v_o);
      compare_value("req_v_o", 0, req_v_o);
    end
    @(posedge clk_i);
    #2;
    report_test(1);
  endtask

  task automatic cold_fetch();
    logic missed;
    int   latency;
    start_test("cold_fetch");
    fetch_one(make_addr(TAG_A, SET_IDX, 1'b1), missed, latency);
    compare_value("cold miss", 1, missed);
    report_test(2);
  endtask

  task automatic repeat_hit();
    logic missed;
    int   latency;
    start_test("repeat_hit");
    fetch_one(make_addr(TAG_A, SET_IDX, 1'b0), missed, latency);
    compare_value("repeat miss", 0, missed);
    compare_value("hit latency", 2, latency);
    report_test(3);
  endtask

  task automatic two_tags_resident();
    logic missed;
    int   latency;
    int   reqs_before;
    start_test("two_tags");
    fetch_one(make_addr(TAG_B, SET_IDX, 1'b0), missed, latency);
    compare_value("second tag miss", 1, missed);
    reqs_before = req_count;
    for (int i = 0; i < 4; i++)
      fetch_one(make_addr((i % 2 == 0) ? TAG_A : TAG_B, SET_IDX, 1'(i / 2)),
                missed, latency);
    compare_value("alternating requests", 0, req_count - reqs_before);
    report_test(4);
  endtask

  task automatic lru_replacement();
    logic             victim;
    icache_pkg::tag_t evicted_tag;
    icache_pkg::tag_t kept_tag;
    logic             missed;
    int               latency;
    start_test("lru_replace");
    victim      = ~mdl_lru[SET_IDX];
    evicted_tag = mdl_tag[victim][SET_IDX];
    kept_tag    = mdl_tag[~victim][SET_IDX];
    fetch_one(make_addr(TAG_C, SET_IDX, 1'b0), missed, latency);
    compare_value("third tag miss", 1, missed);
    fetch_one(make_addr(kept_tag, SET_IDX, 1'b1), missed, latency);
    compare_value("kept tag miss", 0, missed);
    fetch_one(make_addr(evicted_tag, SET_IDX, 1'b1), missed, latency);
    compare_value("evicted tag miss", 1, missed);
    report_test(5);
  endtask

  task automatic hit_stream();
    icache_pkg::addr_t addr;
    icache_pkg::addr_t exp_q [$];
    logic [31:0]       rnd;
    int                exp_miss;
    int                acc_cycle;
    int                reqs_before;
    start_test("hit_stream");
    // Cold fetches offered back to back keep decode and lookup busy through a miss
    exp_miss    = 0;
    reqs_before = req_count;
    res_data.delete();
    res_cycle.delete();
    for (int idx = 8; idx < 12; idx++)
    begin
      addr = make_addr(STREAM_TAG, 4'(idx), 1'b0);
      exp_q.push_back(addr);
      if (!model_access(addr))
        exp_miss++;
      issue_fetch(addr, acc_cycle);
    end
    v_i = 1'b0;
    wait_results(4);
    compare_value("prefill requests", exp_miss, req_count - reqs_before);
    for (int i = 0; i < res_data.size() && i < 4; i++)
      compare_value("prefill instruction", expected_instr(exp_q[i]), res_data[i]);
    exp_q.delete();
    reqs_before = req_count;
    res_data.delete();
    res_cycle.delete();
    gap_mode = 1'b1;
    for (int i = 0; i < STREAM_LEN; i++)
    begin
      rnd  = next_random();
      addr = make_addr(STREAM_TAG, 4'(8 + rnd[1:0]), rnd[2]);
      exp_q.push_back(addr);
      void'(model_access(addr));
      issue_fetch(addr, acc_cycle);
    end
    v_i = 1'b0;
    wait_results(STREAM_LEN);
    gap_mode = 1'b0;
    repeat (10)
    begin
      @(posedge clk_i);
      #2;
    end
    compare_value("stream result count", STREAM_LEN, res_data.size());
    for (int i = 0; i < res_data.size() && i < STREAM_LEN; i++)
      compare_value("stream instruction", expected_instr(exp_q[i]), res_data[i]);
    compare_value("stream requests", 0, req_count - reqs_before);
    report_test(6);
  endtask

  initial
  begin : main
    reset_i       = 1'b1;
    addr_i        = '0;
    v_i           = 1'b0;
    yumi_i        = 1'b0;
    req_yumi_i    = 1'b0;
    fill_v_i      = 1'b0;
    fill_data_i   = '0;
    gap_mode      = 1'b0;
    rng_state     = 32'd53;
    cycle         = 0;
    errors        = 0;
    checks        = 0;
    tests_done    = 0;
    req_count     = 0;
    last_req_addr = '0;
    cur_test      = "reset";
    for (int s = 0; s < `ICACHE_SETS; s++)
    begin
      mdl_lru[s] = 1'b0;
      for (int w = 0; w < `ICACHE_WAYS; w++)
      begin
        mdl_valid[w][s] = 1'b0;
        mdl_tag[w][s]   = '0;
      end
    end
    repeat (8) @(posedge clk_i);
    #2;
    reset_i = 1'b0;

    reset_idle();
    cold_fetch();
    repeat_hit();
    two_tags_resident();
    lru_replacement();
    hit_stream();

    $display("tests %0d, checks %0d, check errors %0d, assertion failures %0d",
             tests_done, checks, errors, dut.u_assert.fail_cnt);
    if (errors == 0 && dut.u_assert.fail_cnt == 0)
      $display("TB PASSED");
    else
      $display("TB FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+.
icache_pkg.sv
icache_decode.sv
icache_lookup.sv
icache_miss_ctrl.sv
icache_top.sv
icache_assert.sv
icache_tb.sv

/* Bender.yml */
package:
  name: icache

sources:
  - include_dirs:
      - .
    files:
      - icache_pkg.sv
      - icache_decode.sv
      - icache_lookup.sv
      - icache_miss_ctrl.sv
      - icache_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - icache_assert.sv
      - icache_tb.sv
